// ==== hw/table_ad_receive.sv ====
// table_ad_receive module, rebuilds link words for one channel and holds its table memory
`timescale 1ns/1ps
`include "table_loader_settings.svh"

module table_ad_receive
    import table_loader_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  link_byte_t ser_d,      // shared link byte, taken only while stb is high
    input  word_kind_t a_not_d,    // shared word kind, steady during the burst
    input  logic       stb,        // this channel's strobe, four cycles per word
    table_rd_if.tbl    rd          // read port toward the mux
);

    localparam logic [`TABLE_AW-1:0] ptr_step = 1;        // pointer advance after each data word

    rx_state_t            state;       // FSM state
    logic [1:0]           byte_cnt;    // bytes taken so far in the current word
    table_word_t          asm_r;       // assembly register, bytes enter at the top
    word_kind_t           kind_r;      // kind of the word being assembled
    logic [`TABLE_AW-1:0] wr_ptr;      // next table entry a data word goes to
    logic                 mem_we;      // table write in the commit cycle

    table_word_t mem [0:(1 << `TABLE_AW) - 1];                // the channel's table

    // only data words touch the table, address words just move the pointer
    assign mem_we = (state == RX_COMMIT) && (kind_r == WORD_DATA);

    // each strobed byte pushes the older ones down, so byte 0 ends up in bits 7:0
    always_ff @(posedge clk) begin
        if (stb) begin
            asm_r <= {ser_d, asm_r[31:8]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            byte_cnt <= 2'd0;
            kind_r   <= WORD_DATA;
            wr_ptr   <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (stb) begin
                        byte_cnt <= 2'd1;         // byte 0 is in
                        kind_r   <= a_not_d;      // sampled once so a later host write cannot alter it
                        state    <= RX_SHIFT;
                    end
                end
                RX_SHIFT: begin
                    if (stb) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3) begin
                            state <= RX_COMMIT;   // byte 3 arrives on this edge
                        end
                    end
                end
                RX_COMMIT: begin
                    if (kind_r == WORD_ADDR) begin
                        wr_ptr <= asm_r[`TABLE_AW-1:0];   // upper address bits are dropped
                    end else begin
                        wr_ptr <= wr_ptr + ptr_step;      // wraps inside the table
                    end
                    state <= RX_IDLE;
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[wr_ptr] <= asm_r;                 // entry at the old pointer value
        end
    end

    // registered read, the word shows up one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            rd.rd_data <= mem[rd.rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd.rd_valid <= 1'b0;
        end else begin
            rd.rd_valid <= rd.rd_en;              // every strobe gets exactly one answer
        end
    end

endmodule

// ==== hw/table_ad_transmit.sv ====
// table_ad_transmit module, serializes host command words into link bytes with channel strobes
`timescale 1ns/1ps
`include "table_loader_settings.svh"

module table_ad_transmit
    import table_loader_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     we,          // single-cycle host write, gap of at least BURST_GAP
    input  word_kind_t               a_not_d_in,  // kind of the word on din, valid with we
    input  table_word_t              din,         // data word or select plus address, valid with we
    output link_byte_t               ser_d,       // current link byte, lsb of the word goes first
    output word_kind_t               a_not_d,     // kind of the word being sent, held for all bytes
    output logic [`NUM_CHANNELS-1:0] chn_stb      // one-hot strobe, high for the four link bytes
);

    table_word_t              d_r;          // shift register, byte 0 sits in the low bits
    link_byte_t               sel_a;        // channel select from the last address word
    logic                     we_r;         // address write delayed so the new select is used
    logic                     busy;         // a burst of four bytes is on the link
    logic [1:0]               burst_cnt;    // bytes still to follow the current one
    logic                     burst_start;  // first strobe cycle begins on the next edge
    logic [`NUM_CHANNELS-1:0] sel;          // one-hot decode of sel_a

    assign ser_d = d_r[7:0];  // the link always shows the low byte of the shift register

    // a data word starts at once, an address word waits one cycle for sel_a to settle
    assign burst_start = (we && (a_not_d_in == WORD_DATA)) || we_r;

    // comparator per channel, a select at or above the channel count matches nothing
    for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : g_sel
        localparam link_byte_t chn_id = i;                // this channel's select value
        assign sel[i] = (sel_a == chn_id);
    end

    always_ff @(posedge clk) begin
        if (we) begin
            d_r <= din;                           // a new word replaces whatever is left
        end else if (busy) begin
            d_r <= d_r >> 8;                      // the receiver has taken the low byte
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_not_d   <= WORD_DATA;
            sel_a     <= '0;
            we_r      <= 1'b0;
            busy      <= 1'b0;
            burst_cnt <= 2'd0;
            chn_stb   <= '0;
        end else begin
            if (we) begin
                a_not_d <= a_not_d_in;            // level stays put until the next host write
            end
            if (we && (a_not_d_in == WORD_ADDR)) begin
                sel_a <= din[31:24];              // top byte of an address word picks the channel
            end
            we_r <= we && (a_not_d_in == WORD_ADDR);
            if (burst_start) begin
                busy      <= 1'b1;
                burst_cnt <= 2'd3;                // three more bytes after the first one
                chn_stb   <= sel;
            end else if (busy) begin
                if (burst_cnt == 2'd0) begin
                    busy    <= 1'b0;              // byte 3 was taken on this edge
                    chn_stb <= '0;
                end else begin
                    burst_cnt <= burst_cnt - 2'd1;
                end
            end
        end
    end

endmodule

// ==== hw/table_loader.sv ====
// table_loader top module with the transmitter, the per-channel receivers and the read mux
`timescale 1ns/1ps
`include "table_loader_settings.svh"

module table_loader
    import table_loader_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 we,          // host command write strobe
    input  word_kind_t           a_not_d_in,  // address or data word, valid with we
    input  table_word_t          din,         // host command word
    input  logic                 rd_en,       // host read strobe
    input  logic [`CHN_W-1:0]    rd_chn,      // channel of the read
    input  logic [`TABLE_AW-1:0] rd_addr,     // table entry of the read
    output table_word_t          rd_data,     // read word, two cycles after rd_en
    output logic                 rd_valid     // marks rd_data
);

    link_byte_t               ser_d;          // shared link byte
    word_kind_t               a_not_d;        // shared word kind on the link
    logic [`NUM_CHANNELS-1:0] chn_stb;        // per-channel byte strobes

    // one read port per channel, the receivers take single elements and the mux the whole array
    table_rd_if rd_if [`NUM_CHANNELS] ();

    // host words go out as four bytes each over the shared link
    table_ad_transmit u_transmit (
        .clk        (clk),
        .rst_n      (rst_n),
        .we         (we),
        .a_not_d_in (a_not_d_in),
        .din        (din),
        .ser_d      (ser_d),
        .a_not_d    (a_not_d),
        .chn_stb    (chn_stb)
    );

    // identical receivers, told apart only by their strobe bit and read port
    for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : g_chn
        table_ad_receive u_receive (
            .clk     (clk),
            .rst_n   (rst_n),
            .ser_d   (ser_d),
            .a_not_d (a_not_d),
            .stb     (chn_stb[i]),
            .rd      (rd_if[i])
        );
    end

    // host read port drains all tables through one registered path
    table_read_mux u_read_mux (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_en    (rd_en),
        .rd_chn   (rd_chn),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .tbl      (rd_if)
    );

endmodule

// ==== hw/table_loader_pkg.sv ====
// table loader package with the word-kind and receiver-state enums and the byte and word types
package table_loader_pkg;

    // meaning of the a_not_d level on the link and at the host port
    typedef enum logic [0:0] {
        WORD_DATA = 1'b0,                 // 32 bits of table data
        WORD_ADDR = 1'b1                  // channel select in the top byte, table address below
    } word_kind_t;

    // receiver FSM states
    typedef enum logic [1:0] {
        RX_IDLE   = 2'd0,                 // waiting for the first byte of a word
        RX_SHIFT  = 2'd1,                 // collecting bytes 1 to 3
        RX_COMMIT = 2'd2                  // word is complete, pointer or table gets updated
    } rx_state_t;

    // one byte on the shared link
    typedef logic [7:0] link_byte_t;

    // one table entry, also the width of a host command word
    typedef logic [31:0] table_word_t;

endpackage

// ==== hw/table_loader_settings.svh ====
// channel count, table address width, read select width and minimum write gap of the table loader
`ifndef TABLE_LOADER_SETTINGS_SVH
`define TABLE_LOADER_SETTINGS_SVH

// number of receiver channels, each with its own table
`define NUM_CHANNELS 4

// low address bits kept from the 24-bit table address, 16 entries per table
`define TABLE_AW 4

// width of the read channel select, log2 of the channel count
`define CHN_W 2

// fewest cycles the host leaves from one write to the next
`define BURST_GAP 6

`endif

// ==== hw/table_rd_if.sv ====
// table_rd_if interface for the per-channel table read port, with tbl and mux modports
`timescale 1ns/1ps
`include "table_loader_settings.svh"

interface table_rd_if
    import table_loader_pkg::*;
();
    logic                 rd_en;          // one-cycle read strobe from the mux
    logic [`TABLE_AW-1:0] rd_addr;        // table entry to read, valid with rd_en
    table_word_t          rd_data;        // registered table word, valid with rd_valid
    logic                 rd_valid;       // follows rd_en by one cycle, there is no back-pressure

    // the table side answers every strobe one cycle later
    modport tbl (
        input  rd_en,
        input  rd_addr,
        output rd_data,
        output rd_valid
    );

    // the mux side issues strobes and collects the answers
    modport mux (
        output rd_en,
        output rd_addr,
        input  rd_data,
        input  rd_valid
    );

endinterface

// ==== hw/table_read_mux.sv ====
// table_read_mux module, steers host reads to one channel table and registers the returned word
`timescale 1ns/1ps
`include "table_loader_settings.svh"

module table_read_mux
    import table_loader_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rd_en,       // host read strobe, one read per cycle at most
    input  logic [`CHN_W-1:0]    rd_chn,      // channel to read, valid with rd_en
    input  logic [`TABLE_AW-1:0] rd_addr,     // table entry to read, valid with rd_en
    output table_word_t          rd_data,     // word read two cycles after the strobe
    output logic                 rd_valid,    // marks rd_data
    table_rd_if.mux              tbl [`NUM_CHANNELS]  // read ports of all channel tables
);

    logic [`CHN_W-1:0]        chn_d;                          // channel of the read in the table stage
    table_word_t              ret_data [`NUM_CHANNELS];       // words coming back from the tables
    logic [`NUM_CHANNELS-1:0] ret_valid;                      // valid flags coming back from the tables

    // strobe goes only to the selected table, the address fans out to all of them
    for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : g_steer
        localparam logic [`CHN_W-1:0] chn_id = i;            // this port's channel number
        assign tbl[i].rd_en   = rd_en && (rd_chn == chn_id);
        assign tbl[i].rd_addr = rd_addr;
        assign ret_data[i]    = tbl[i].rd_data;               // gathered so they can be indexed
        assign ret_valid[i]   = tbl[i].rd_valid;
    end

    // channel number travels alongside the registered table read
    always_ff @(posedge clk) begin
        chn_d <= rd_chn;
    end

    always_ff @(posedge clk) begin
        if (ret_valid[chn_d]) begin
            rd_data <= ret_data[chn_d];           // second register stage of the read path
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= ret_valid[chn_d];         // only the read channel can be answering
        end
    end

endmodule

// ==== table_loader.f ====
+incdir+hw
hw/table_loader_pkg.sv
hw/table_rd_if.sv
hw/table_ad_transmit.sv
hw/table_ad_receive.sv
hw/table_read_mux.sv
hw/table_loader.sv
tb/tb_table_loader.sv

// ==== tb/tb_table_loader.sv ====
// tb_table_loader testbench with clock, reset, LFSR stimulus, table model, checks, watchdog and reporting
`timescale 1ns/1ps
`include "table_loader_settings.svh"

module tb_table_loader
    import table_loader_pkg::*;
();

    localparam int entries    = 1 << `TABLE_AW;                       // entries per table
    localparam int burst_len  = 8;                                    // data words of the late writer
    localparam int side_reads = (1 + burst_len) * `BURST_GAP;         // reads issued next to it
    // writes per test: 4, fill, wrap, isolation, late writer
    localparam int num_writes = 4 + `NUM_CHANNELS * (1 + entries) + 3 + 14 + 1 + burst_len;
    // reads per test: 4, full dump, wrap, full dump, random, side reads, full dump
    localparam int num_reads  = 4 + 3 * `NUM_CHANNELS * entries + 3 + 200 + side_reads;
    localparam int watchdog_cycles = 10 + num_writes * `BURST_GAP + num_reads + 200;
    localparam logic [`CHN_W-1:0] busy_chn = `NUM_CHANNELS - 1;       // channel written during reads

    logic                 clk;
    logic                 rst_n;
    logic                 we;
    word_kind_t           a_not_d_in;
    table_word_t          din;
    logic                 rd_en;
    logic [`CHN_W-1:0]    rd_chn;
    logic [`TABLE_AW-1:0] rd_addr;
    table_word_t          rd_data;
    logic                 rd_valid;

    logic [31:0]          lfsr;                                  // stimulus LFSR state
    table_word_t          model_mem [`NUM_CHANNELS][entries];    // expected table contents
    logic [`TABLE_AW-1:0] model_ptr [`NUM_CHANNELS];             // expected write pointers
    link_byte_t           model_sel;                             // select of the last address word
    table_word_t          exp_q [$];                             // words owed by pending reads
    int                   errors;                                // failed checks over the whole run
    int                   errors_at_start;                       // error count when a test began
    int                   tests_passed;
    int                   tests_failed;

    table_loader u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .we         (we),
        .a_not_d_in (a_not_d_in),
        .din        (din),
        .rd_en      (rd_en),
        .rd_chn     (rd_chn),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                                  // 20 ns period
    end

    // rd_valid must mirror rd_en two edges back, never more and never less
    rd_latency_check: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid == $past(rd_en, 2))
        else begin
            errors++;
            $display("rd_valid does not follow rd_en by two cycles at %0t", $time);
        end

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin : check_read_data
        table_word_t exp_word;
        if (rst_n) begin
            if (rd_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;                                    // covers rd_valid before the first read
                    $display("rd_valid is high with no read outstanding at %0t", $time);
                end else begin
                    exp_word = exp_q.pop_front();
                    rd_data_check: assert (rd_data === exp_word)
                        else begin
                            errors++;
                            $display("mismatch rd_data expected %h actual %h at %0t",
                                     exp_word, rd_data, $time);
                        end
                end
            end else if (rd_valid !== 1'b0) begin
                errors++;
                $display("rd_valid is unknown at %0t", $time);
            end
        end
    end

    // taps 32, 22, 2 and 1, one step per bit handed out
    function automatic table_word_t take_bits(input int n);
        table_word_t bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // one host write, the model follows the pointer rules right away
    task automatic write_word(input word_kind_t kind, input table_word_t word);
        @(negedge clk);
        we         = 1'b1;
        a_not_d_in = kind;
        din        = word;
        if (kind == WORD_ADDR) begin
            model_sel = word[31:24];
            if (model_sel < `NUM_CHANNELS) begin
                model_ptr[model_sel] = word[`TABLE_AW-1:0];     // upper address bits fall away
            end
        end else if (model_sel < `NUM_CHANNELS) begin
            model_mem[model_sel][model_ptr[model_sel]] = word;
            model_ptr[model_sel] = model_ptr[model_sel] + 1'b1; // wraps with the pointer width
        end
        @(negedge clk);
        we = 1'b0;
        repeat (`BURST_GAP - 2) @(negedge clk);                  // next write lands BURST_GAP later
    endtask

    // starts one read and records what it must return
    task automatic issue_read(input logic [`CHN_W-1:0] chn, input logic [`TABLE_AW-1:0] addr);
        @(negedge clk);
        rd_en   = 1'b1;
        rd_chn  = chn;
        rd_addr = addr;
        exp_q.push_back(model_mem[chn][addr]);
    endtask

    // drops the strobe and waits for every pending word to come back
    task automatic finish_reads();
        int waited;
        waited = 0;
        @(negedge clk);
        rd_en = 1'b0;
        while (exp_q.size() != 0 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d reads got no answer from the read port", exp_q.size());
            exp_q.delete();
        end
    endtask

    // back-to-back reads of every entry of every channel
    task automatic read_all();
        for (int c = 0; c < `NUM_CHANNELS; c++) begin
            for (int a = 0; a < entries; a++) begin
                issue_read(c[`CHN_W-1:0], a[`TABLE_AW-1:0]);
            end
        end
        finish_reads();
    endtask

    task automatic close_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin : run_tests
        table_word_t          burst_data [burst_len];   // data for the writer of the last test
        logic [`CHN_W-1:0]    side_chn [side_reads];    // read channels next to that writer
        logic [`TABLE_AW-1:0] side_addr [side_reads];
        table_word_t          base;
        logic [`CHN_W-1:0]    chn_r;
        logic [`TABLE_AW-1:0] addr_r;

        lfsr            = 32'hc8ba;
        errors          = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        model_sel       = '0;                                    // the DUT resets its select to 0
        for (int c = 0; c < `NUM_CHANNELS; c++) begin
            model_ptr[c] = '0;
        end
        rst_n      = 1'b0;
        we         = 1'b0;
        a_not_d_in = WORD_DATA;
        din        = '0;
        rd_en      = 1'b0;
        rd_chn     = '0;
        rd_addr    = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // data words with no address go to channel 0 from entry 0
        for (int i = 0; i < 4; i++) begin
            write_word(WORD_DATA, take_bits(32));
        end
        for (int i = 0; i < 4; i++) begin
            issue_read('0, i[`TABLE_AW-1:0]);
        end
        finish_reads();
        close_test("reset_defaults");

        // one address word and a full table of data per channel, so every entry is known
        for (int c = 0; c < `NUM_CHANNELS; c++) begin
            base        = take_bits(24);
            base[31:24] = c[7:0];
            write_word(WORD_ADDR, base);
            for (int i = 0; i < entries; i++) begin
                write_word(WORD_DATA, take_bits(32));
            end
        end
        read_all();
        close_test("address_then_data");

        write_word(WORD_ADDR, {8'd2, 24'h0fffff});               // low bits select entry 15
        write_word(WORD_DATA, take_bits(32));
        write_word(WORD_DATA, take_bits(32));                    // lands in entry 0
        issue_read(2'd2, 4'd15);
        issue_read(2'd2, 4'd0);
        issue_read(2'd2, 4'd1);                                  // must still hold its old word
        finish_reads();
        close_test("pointer_wrap");

        base        = take_bits(24);
        base[31:24] = 8'd1;
        write_word(WORD_ADDR, base);
        for (int i = 0; i < 5; i++) begin
            write_word(WORD_DATA, take_bits(32));
        end
        base        = take_bits(24);
        base[31:24] = 8'(`NUM_CHANNELS);                         // first select past the last channel
        write_word(WORD_ADDR, base);
        for (int i = 0; i < 3; i++) begin
            write_word(WORD_DATA, take_bits(32));
        end
        base        = take_bits(24);
        base[31:24] = 8'hc3;
        write_word(WORD_ADDR, base);
        for (int i = 0; i < 3; i++) begin
            write_word(WORD_DATA, take_bits(32));
        end
        read_all();
        close_test("channel_isolation");

        for (int i = 0; i < 200; i++) begin
            chn_r  = take_bits(`CHN_W);
            addr_r = take_bits(`TABLE_AW);
            issue_read(chn_r, addr_r);
        end
        finish_reads();
        close_test("random_back_to_back_reads");

        // all random values are drawn here so the two processes below share no LFSR state
        base        = take_bits(24);
        base[31:24] = 8'(busy_chn);
        for (int i = 0; i < burst_len; i++) begin
            burst_data[i] = take_bits(32);
        end
        for (int i = 0; i < side_reads; i++) begin
            side_chn[i]  = take_bits(`CHN_W);
            side_addr[i] = take_bits(`TABLE_AW);
            if (side_chn[i] == busy_chn) begin
                side_chn[i] = busy_chn + 1'b1;                   // steer away from the written table
            end
        end
        fork
            begin
                write_word(WORD_ADDR, base);
                for (int i = 0; i < burst_len; i++) begin
                    write_word(WORD_DATA, burst_data[i]);
                end
            end
            begin
                for (int i = 0; i < side_reads; i++) begin
                    issue_read(side_chn[i], side_addr[i]);
                end
            end
        join
        finish_reads();
        read_all();
        close_test("reads_during_writes");

        $display("tests passed %0d failed %0d, failed checks %0d", tests_passed, tests_failed,
                 errors);
        if (tests_failed == 0 && errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // sized from the write and read counts of all tests plus a margin
    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the tests did not finish", watchdog_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule
